// File: sim.f
+incdir+include
design/decodePkg.sv
design/ctrlBus.sv
design/controlDecoder.sv
design/immGenerator.sv
design/regFile.sv
design/issueLatch.sv
design/instDecodeTop.sv
tests/decodeTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = decodeTb
FILELIST  = sim.f
OBJDIR    = obj_dir
PASSMSG   = test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

// File: include/decodeModel.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

typedef struct packed {
    decodePkg::aluCtrlT aluCtrl;
    decodePkg::branchT  branch;
    logic               memRead;
    logic               memWrite;
    logic               memToReg;
    logic               regWrite;
    decodePkg::memOpT   memOp;
    logic               illegal;
    logic               halt;
} ctrlExpT;

// immediate straight from the format drawings
function automatic decodePkg::xlenT modelImm(input decodePkg::instT inst);
    case (inst[6:2])
        decodePkg::opStore:  return {{52{inst[31]}}, inst[31:25], inst[11:7]};
        decodePkg::opBranch: return {{51{inst[31]}}, inst[31], inst[7], inst[30:25],
                                     inst[11:8], 1'b0};
        decodePkg::opLui, decodePkg::opAuipc: return {{32{inst[31]}}, inst[31:12], 12'h000};
        decodePkg::opJal:    return {{43{inst[31]}}, inst[31], inst[19:12], inst[20],
                                     inst[30:21], 1'b0};
        default:             return {{52{inst[31]}}, inst[31:20]};
    endcase
endfunction

function automatic ctrlExpT modelCtrl(input decodePkg::instT inst);
    ctrlExpT    e;
    logic [4:0] g;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       shift;
    logic       known;
    g     = inst[6:2];
    f3    = inst[14:12];
    f7    = inst[31:25];
    shift = (f3[1:0] == 2'b01);
    known = g inside {5'b00000, 5'b01000, 5'b00100, 5'b00110, 5'b01100, 5'b01110,
                      5'b01101, 5'b00101, 5'b11011, 5'b11001, 5'b11000, 5'b11100};
    e = '0;
    e.memRead  = (g == decodePkg::opLoad);
    e.memToReg = e.memRead;
    e.memWrite = (g == decodePkg::opStore);
    e.regWrite = !(g inside {decodePkg::opBranch, decodePkg::opStore, decodePkg::opSystem});
    e.memOp    = f3;
    e.halt     = (g == decodePkg::opSystem);
    e.aluCtrl[5] = (g inside {decodePkg::opOp, decodePkg::opOpW}) && f7[0];
    e.aluCtrl[4] = (g inside {decodePkg::opOpImmW, decodePkg::opOpW});
    if (g == decodePkg::opLui) e.aluCtrl[3:0] = 4'b1111;
    if (g inside {decodePkg::opOpImm, decodePkg::opOpImmW})
        e.aluCtrl[3:0] = {f7[5] && (f3 == 3'b101), f3};
    if (g inside {decodePkg::opOp, decodePkg::opOpW}) e.aluCtrl[3:0] = {f7[5], f3};
    if (g == decodePkg::opBranch && f3[2:1] != 2'b01) begin
        e.aluCtrl[3:0] = {3'b001, f3[1]};
        e.branch       = {1'b1, f3[2], f3[0]};
    end
    if (g == decodePkg::opJal) e.branch = decodePkg::branchJal;
    if (g == decodePkg::opJalr) e.branch = decodePkg::branchJalr;
    e.illegal = (inst[1:0] != 2'b11) || !known
        || (g == decodePkg::opJalr && f3 != 3'b000)
        || (g == decodePkg::opBranch && f3[2:1] == 2'b01)
        || (g == decodePkg::opLoad && f3 == 3'b111)
        || (g == decodePkg::opStore && f3 > 3'b011)
        || (g == decodePkg::opOpImm && shift && !(f7[6:1] inside {6'b000000, 6'b010000}))
        || (g == decodePkg::opOpImmW && shift && !(f7 inside {7'b0000000, 7'b0100000}))
        || (g inside {decodePkg::opOp, decodePkg::opOpW}
            && !(f7 inside {7'b0000000, 7'b0100000, 7'b0000001}));
    return e;
endfunction

`endif

// File: tests/decodeTb.sv
`timescale 1ns/1ns
`default_nettype none

module decodeTb;
    import decodePkg::*;

    `include "decodeModel.svh"

    logic    clock     = 1'b0;
    logic    reset     = 1'b1;
    logic    instValid = 1'b0;
    instT    inst      = '0;
    pcT      pc        = '0;
    logic    wbEnable  = 1'b0;
    regAddrT wbAddr    = '0;
    xlenT    wbData    = '0;

    logic    issueValid;
    aluCtrlT issueAluCtrl;
    xlenT    issueOpA;
    xlenT    issueOpB;
    xlenT    issueRs2Data;
    xlenT    issueImm;
    regAddrT issueRd;
    branchT  issueBranch;
    logic    issueMemRead;
    logic    issueMemWrite;
    logic    issueMemToReg;
    logic    issueRegWrite;
    memOpT   issueMemOp;
    logic    issueIllegal;
    logic    issueHalt;

    int      seed     = 32'h746c;
    int      errors   = 0;
    int      timeouts = 0;
    xlenT    shadow [0:31];   // what the register file should hold

    // expected bundle, staged at the strobe and moved on when the DUT samples it
    string   nextName;
    ctrlExpT nextCtrl;
    xlenT    nextImm, nextOpA, nextOpB, nextRs2;
    regAddrT nextRd;
    logic    nextOps;
    string   expName;
    ctrlExpT expCtrl;
    xlenT    expImm, expOpA, expOpB, expRs2;
    regAddrT expRd;
    logic    expOps;
    logic    expValid = 1'b0;
    logic    started  = 1'b0;
    ctrlExpT actualCtrl;

    instDecodeTop dut (.*);

    always #5 clock = ~clock;

    assign actualCtrl = {issueAluCtrl, issueBranch, issueMemRead, issueMemWrite,
                         issueMemToReg, issueRegWrite, issueMemOp, issueIllegal, issueHalt};

    always @(posedge clock) begin
        expValid <= instValid;   // pulse follows the strobe by one edge
        if (reset) begin
            started <= 1'b0;     // idle outputs expected again
        end else if (instValid) begin
            started <= 1'b1;
            expName <= nextName;
            expCtrl <= nextCtrl;
            expImm  <= nextImm;
            expOpA  <= nextOpA;
            expOpB  <= nextOpB;
            expRs2  <= nextRs2;
            expRd   <= nextRd;
            expOps  <= nextOps;
        end
    end

    pulseCheck: assert property (@(negedge clock) disable iff (reset) issueValid == expValid)
        else begin
            errors = errors + 1;
            $display("FAILED pulse %s expected %0b actual %0b", expName, expValid, issueValid);
        end

    idleCheck: assert property (@(negedge clock) disable iff (reset) started ||
            {issueValid, issueRegWrite, issueMemRead, issueMemWrite, issueIllegal, issueHalt} == 6'b0)
        else begin
            errors = errors + 1;
            $display("FAILED reset expected 000000 actual %b", {issueValid, issueRegWrite,
                     issueMemRead, issueMemWrite, issueIllegal, issueHalt});
        end

    ctrlCheck: assert property (@(negedge clock) disable iff (reset)
            !issueValid || actualCtrl == expCtrl)
        else begin
            errors = errors + 1;
            $display("FAILED ctrl %s expected %h actual %h", expName, expCtrl, actualCtrl);
        end

    immCheck: assert property (@(negedge clock) disable iff (reset)
            !issueValid || issueImm == expImm)
        else begin
            errors = errors + 1;
            $display("FAILED imm %s expected %h actual %h", expName, expImm, issueImm);
        end

    opACheck: assert property (@(negedge clock) disable iff (reset)
            !(issueValid && expOps) || issueOpA == expOpA)
        else begin
            errors = errors + 1;
            $display("FAILED opA %s expected %h actual %h", expName, expOpA, issueOpA);
        end

    opBCheck: assert property (@(negedge clock) disable iff (reset)
            !(issueValid && expOps) || issueOpB == expOpB)
        else begin
            errors = errors + 1;
            $display("FAILED opB %s expected %h actual %h", expName, expOpB, issueOpB);
        end

    rs2Check: assert property (@(negedge clock) disable iff (reset)
            !issueValid || (issueRs2Data == expRs2 && issueRd == expRd))
        else begin
            errors = errors + 1;
            $display("FAILED rs2/rd %s expected %h/%0d actual %h/%0d", expName,
                     expRs2, expRd, issueRs2Data, issueRd);
        end

    function automatic logic [31:0] nextRandom();
        return $random(seed);
    endfunction

    function automatic instT encode(input logic [6:0] f7, input regAddrT rs2, input regAddrT rs1,
                                    input logic [2:0] f3, input regAddrT rd, input opGroupT g);
        return {f7, rs2, rs1, f3, rd, g, 2'b11};
    endfunction

    function automatic xlenT operandA(input instT i, input pcT p);
        if (i[6:2] inside {opAuipc, opJal, opJalr}) begin
            return p;
        end
        return shadow[i[19:15]];
    endfunction

    function automatic xlenT operandB(input instT i);
        case (i[6:2])
            opJal, opJalr:         return xlenT'(4);   // link value
            opOp, opOpW, opBranch: return shadow[i[24:20]];
            default:               return modelImm(i);
        endcase
    endfunction

    function automatic logic checksOperands(input instT i);
        return i[6:2] inside {opLoad, opStore, opOpImm, opOpImmW, opOp, opOpW,
                              opLui, opAuipc, opJal, opJalr, opBranch};
    endfunction

    task automatic strobe(input string name, input instT i, input pcT p);
        @(posedge clock);
        instValid <= 1'b1;
        inst      <= i;
        pc        <= p;
        nextName  <= name;
        nextCtrl  <= modelCtrl(i);
        nextImm   <= modelImm(i);
        nextOpA   <= operandA(i, p);
        nextOpB   <= operandB(i);
        nextRs2   <= shadow[i[24:20]];
        nextRd    <= i[11:7];
        nextOps   <= checksOperands(i);
    endtask

    task automatic endStrobe();
        @(posedge clock);
        instValid <= 1'b0;
    endtask

    task automatic awaitIssue(input string name);
        int n;
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (!issueValid && n < 8);
        if (!issueValid) begin
            timeouts++;
            $display("no issueValid pulse within 8 cycles for test %s", name);
        end
    endtask

    task automatic runInst(input string name, input instT i, input pcT p);
        strobe(name, i, p);
        endStrobe();
        awaitIssue(name);
    endtask

    task automatic writeReg(input regAddrT a, input xlenT d);
        @(posedge clock);
        wbEnable <= 1'b1;
        wbAddr   <= a;
        wbData   <= d;
        if (a != '0) begin
            shadow[a] = d;
        end
        @(posedge clock);
        wbEnable <= 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        regAddrT     a1;
        regAddrT     a2;
        instT        i;
        opGroupT     groups [12];
        logic [6:0]  f7s [3];
        groups = '{opLoad, opStore, opOpImm, opOpImmW, opOp, opOpW,
                   opLui, opAuipc, opJal, opJalr, opBranch, opSystem};
        f7s = '{7'h00, 7'h20, 7'h01};
        for (int k = 0; k < 32; k++) begin
            shadow[k] = '0;
        end
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        repeat (3) @(posedge clock);   // idle outputs checked here

        strobe("backToBack", encode(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, opOp), 64'h1000);
        strobe("backToBack", encode(7'h00, 5'd0, 5'd1, 3'b000, 5'd4, opOpImm), 64'h1004);
        endStrobe();
        awaitIssue("backToBack");

        runInst("regZero", encode(7'h00, 5'd4, 5'd3, 3'b000, 5'd5, opOp), 64'h2000);
        for (int k = 0; k < 10; k++) begin
            r  = nextRandom();
            a1 = r[4:0];
            a2 = r[12:8];
            writeReg(a1, {nextRandom(), nextRandom()});
            writeReg(a2, {nextRandom(), nextRandom()});
            runInst("regFile", encode(7'h00, a2, a1, 3'b000, r[20:16], opOp),
                    {nextRandom(), nextRandom()});
        end
        writeReg(5'd0, {nextRandom(), nextRandom()});
        runInst("regX0", encode(7'h00, 5'd0, 5'd0, 3'b000, 5'd1, opOp), 64'h3000);

        for (int k = 0; k < 36; k++) begin
            r = nextRandom();
            case (k % 6)
                0: i = {r[31:15], 3'b000, r[11:7], opOpImm, 2'b11};
                1: i = {r[31:15], 1'b0, r[13:12], r[11:7], opStore, 2'b11};
                2: i = {r[31:15], 3'b000, r[11:7], opBranch, 2'b11};
                3: i = {r[31:7], opLui, 2'b11};
                4: i = {r[31:7], opAuipc, 2'b11};
                default: i = {r[31:7], opJal, 2'b11};
            endcase
            runInst("immediate", i, {nextRandom(), nextRandom()});
        end

        // every group, funct3 and funct7 choice
        for (int g = 0; g < 12; g++) begin
            for (int f = 0; f < 8; f++) begin
                for (int v = 0; v < 3; v++) begin
                    r = nextRandom();
                    runInst("ctrlTable", encode(f7s[v], r[4:0], r[9:5], f[2:0], r[14:10],
                            groups[g]), {nextRandom(), nextRandom()});
                end
            end
        end
        runInst("ebreak", 32'h00100073, 64'h4000);

        runInst("illegalLowBits", encode(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, opOp) & ~32'h1,
                64'h5000);
        runInst("illegalOpcode", encode(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, 5'b00010), 64'h5004);
        runInst("illegalJalr", encode(7'h00, 5'd2, 5'd1, 3'b001, 5'd3, opJalr), 64'h5008);
        runInst("illegalBranch", encode(7'h00, 5'd2, 5'd1, 3'b010, 5'd3, opBranch), 64'h500c);
        runInst("illegalLoad", encode(7'h00, 5'd2, 5'd1, 3'b111, 5'd3, opLoad), 64'h5010);
        runInst("illegalStore", encode(7'h00, 5'd2, 5'd1, 3'b100, 5'd3, opStore), 64'h5014);
        runInst("illegalShift", encode(7'h04, 5'd2, 5'd1, 3'b001, 5'd3, opOpImm), 64'h5018);
        runInst("illegalOpF7", encode(7'h02, 5'd2, 5'd1, 3'b000, 5'd3, opOp), 64'h501c);

        // reset again while flags and registers hold values
        writeReg(5'd9, {nextRandom(), nextRandom()} | 64'h1);
        runInst("preReset", encode(7'h00, 5'd2, 5'd1, 3'b111, 5'd3, opLoad), 64'h6000);
        @(posedge clock);
        reset <= 1'b1;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        for (int k = 0; k < 32; k++) begin
            shadow[k] = '0;
        end
        repeat (3) @(posedge clock);   // flags must read low again
        runInst("resetRegs", encode(7'h00, 5'd9, 5'd9, 3'b000, 5'd1, opOp), 64'h6004);

        repeat (3) @(posedge clock);
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/instDecodeTop.sv
`timescale 1ns/1ns
`default_nettype none

module instDecodeTop (
    input  logic               clock,
    input  logic               reset,
    input  logic               instValid,
    input  decodePkg::instT    inst,
    input  decodePkg::pcT      pc,
    input  logic               wbEnable,
    input  decodePkg::regAddrT wbAddr,
    input  decodePkg::xlenT    wbData,
    output logic               issueValid,
    output decodePkg::aluCtrlT issueAluCtrl,
    output decodePkg::xlenT    issueOpA,
    output decodePkg::xlenT    issueOpB,
    output decodePkg::xlenT    issueRs2Data,
    output decodePkg::xlenT    issueImm,
    output decodePkg::regAddrT issueRd,
    output decodePkg::branchT  issueBranch,
    output logic               issueMemRead,
    output logic               issueMemWrite,
    output logic               issueMemToReg,
    output logic               issueRegWrite,
    output decodePkg::memOpT   issueMemOp,
    output logic               issueIllegal,
    output logic               issueHalt
);
    import decodePkg::*;

    regAddrT rs1Addr;
    regAddrT rs2Addr;
    regAddrT rd;
    xlenT    imm;
    xlenT    rs1Data;
    xlenT    rs2Data;

    assign rs1Addr = inst[19:15];
    assign rs2Addr = inst[24:20];
    assign rd      = inst[11:7];

    ctrlBus ctrl ();

    controlDecoder decoder (.inst(inst), .ctrl(ctrl.controller));

    immGenerator immGen (.inst(inst), .ctrl(ctrl.immSource), .imm(imm));

    regFile regs (
        .clock(clock), .reset(reset),
        .rs1Addr(rs1Addr), .rs2Addr(rs2Addr),
        .rs1Data(rs1Data), .rs2Data(rs2Data),
        .wbEnable(wbEnable), .wbAddr(wbAddr), .wbData(wbData)
    );

    issueLatch latch (
        .clock(clock), .reset(reset), .instValid(instValid),
        .pc(pc), .rd(rd), .ctrl(ctrl.consumer), .imm(imm),
        .rs1Data(rs1Data), .rs2Data(rs2Data),
        .issueValid(issueValid), .issueAluCtrl(issueAluCtrl),
        .issueOpA(issueOpA), .issueOpB(issueOpB),
        .issueRs2Data(issueRs2Data), .issueImm(issueImm), .issueRd(issueRd),
        .issueBranch(issueBranch), .issueMemRead(issueMemRead),
        .issueMemWrite(issueMemWrite), .issueMemToReg(issueMemToReg),
        .issueRegWrite(issueRegWrite), .issueMemOp(issueMemOp),
        .issueIllegal(issueIllegal), .issueHalt(issueHalt)
    );

endmodule

`default_nettype wire

// File: design/issueLatch.sv
`timescale 1ns/1ns
`default_nettype none

module issueLatch (
    input  logic               clock,
    input  logic               reset,
    input  logic               instValid,
    input  decodePkg::pcT      pc,
    input  decodePkg::regAddrT rd,
    ctrlBus.consumer           ctrl,
    input  decodePkg::xlenT    imm,
    input  decodePkg::xlenT    rs1Data,
    input  decodePkg::xlenT    rs2Data,
    output logic               issueValid,
    output decodePkg::aluCtrlT issueAluCtrl,
    output decodePkg::xlenT    issueOpA,
    output decodePkg::xlenT    issueOpB,
    output decodePkg::xlenT    issueRs2Data,
    output decodePkg::xlenT    issueImm,
    output decodePkg::regAddrT issueRd,
    output decodePkg::branchT  issueBranch,
    output logic               issueMemRead,
    output logic               issueMemWrite,
    output logic               issueMemToReg,
    output logic               issueRegWrite,
    output decodePkg::memOpT   issueMemOp,
    output logic               issueIllegal,
    output logic               issueHalt
);
    import decodePkg::*;

    xlenT opA;
    xlenT opB;

    assign opA = ctrl.aSrc ? pc : rs1Data;

    always_comb begin
        case (ctrl.bSrc)
            bSrcFour: opB = xlenT'(4);
            bSrcImm:  opB = imm;
            default:  opB = rs2Data;
        endcase
    end

    // one pulse per strobe
    always_ff @(posedge clock) begin
        if (reset) begin
            issueValid    <= 1'b0;
            issueMemRead  <= 1'b0;
            issueMemWrite <= 1'b0;
            issueMemToReg <= 1'b0;
            issueRegWrite <= 1'b0;
            issueIllegal  <= 1'b0;
            issueHalt     <= 1'b0;
        end else begin
            issueValid <= instValid;
            if (instValid) begin
                issueMemRead  <= ctrl.memRead;
                issueMemWrite <= ctrl.memWrite;
                issueMemToReg <= ctrl.memToReg;
                issueRegWrite <= ctrl.regWrite;
                issueIllegal  <= ctrl.illegal;
                issueHalt     <= ctrl.halt;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (instValid) begin
            issueAluCtrl <= ctrl.aluCtrl;
            issueOpA     <= opA;
            issueOpB     <= opB;
            issueRs2Data <= rs2Data;  // store data
            issueImm     <= imm;      // branch target offset
            issueRd      <= rd;
            issueBranch  <= ctrl.branch;
            issueMemOp   <= ctrl.memOp;
        end
    end

endmodule

`default_nettype wire

// File: design/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile (
    input  logic               clock,
    input  logic               reset,
    input  decodePkg::regAddrT rs1Addr,
    input  decodePkg::regAddrT rs2Addr,
    output decodePkg::xlenT    rs1Data,
    output decodePkg::xlenT    rs2Data,
    input  logic               wbEnable,
    input  decodePkg::regAddrT wbAddr,
    input  decodePkg::xlenT    wbData
);
    import decodePkg::*;

    xlenT regs [1:regCount-1]; // no storage for x0

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 1; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEnable && (wbAddr != '0)) begin
            regs[wbAddr] <= wbData;
        end
    end

    // no bypass from the write port
    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule

`default_nettype wire

// File: design/immGenerator.sv
`timescale 1ns/1ns
`default_nettype none

module immGenerator (
    input  decodePkg::instT  inst,
    ctrlBus.immSource        ctrl,
    output decodePkg::xlenT  imm
);
    import decodePkg::*;

    extOpT ext;
    logic  sign;

    assign ext  = ctrl.extOp;
    assign sign = inst[31];

    // every format puts the sign at inst[31]
    assign imm[63:31] = {33{sign}};

    // only U carries real bits here
    assign imm[30:20] = ext[2] ? inst[30:20] : {11{sign}};

    // U and J
    assign imm[19:12] = (~ext[1] & ext[0]) ? inst[19:12] : {8{sign}};

    always_comb begin
        if (ext[2]) begin
            imm[11] = 1'b0;      // U
        end else if (!ext[0]) begin
            imm[11] = sign;      // I, S
        end else if (ext[1]) begin
            imm[11] = inst[7];   // B
        end else begin
            imm[11] = inst[20];  // J
        end
    end

    assign imm[10:5] = ext[2] ? 6'b000000 : inst[30:25];

    assign imm[4:1] = ext[2] ? 4'b0000 :
                      ext[1] ? inst[11:8] : inst[24:21]; // S,B vs I,J

    assign imm[0] = ext[0] ? 1'b0 :
                    ext[1] ? inst[7] : inst[20]; // B, U, J have bit 0 clear

endmodule

`default_nettype wire

// File: design/controlDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module controlDecoder (
    input  decodePkg::instT inst,
    ctrlBus.controller      ctrl
);
    import decodePkg::*;

    opGroupT    group;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       isShift;
    extOpT      extOp;
    bSrcT       bSrc;
    logic [3:0] aluLow;
    branchT     branch;
    logic       groupErr;

    assign group   = inst[6:2];
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign isShift = (funct3 == 3'b001) || (funct3 == 3'b101);

    always_comb begin
        extOp    = extI;
        bSrc     = bSrcRs2;
        aluLow   = 4'b0000;
        branch   = branchNone;
        groupErr = 1'b0;
        case (group)
            opSystem: begin // ebreak
                bSrc = bSrcFour;
            end
            opLui: begin
                extOp  = extU;
                bSrc   = bSrcImm;
                aluLow = 4'b1111; // pass operand B
            end
            opAuipc: begin
                extOp = extU;
                bSrc  = bSrcImm;
            end
            opJal: begin
                extOp  = extJ;
                bSrc   = bSrcFour; // link value pc+4
                branch = branchJal;
            end
            opJalr: begin
                bSrc     = bSrcFour;
                branch   = branchJalr;
                groupErr = (funct3 != 3'b000);
            end
            opBranch: begin
                extOp = extB;
                case (funct3)
                    3'b000: begin
                        aluLow = 4'b0010;
                        branch = branchEq;
                    end
                    3'b001: begin
                        aluLow = 4'b0010;
                        branch = branchNe;
                    end
                    3'b100: begin
                        aluLow = 4'b0010;
                        branch = branchLt;
                    end
                    3'b101: begin
                        aluLow = 4'b0010;
                        branch = branchGe;
                    end
                    3'b110: begin // unsigned compare
                        aluLow = 4'b0011;
                        branch = branchLt;
                    end
                    3'b111: begin
                        aluLow = 4'b0011;
                        branch = branchGe;
                    end
                    default: begin
                        groupErr = 1'b1;
                    end
                endcase
            end
            opLoad: begin
                bSrc     = bSrcImm;
                groupErr = (funct3 == 3'b111);
            end
            opStore: begin
                extOp    = extS;
                bSrc     = bSrcImm;
                groupErr = funct3[2];   // only sb..sd
            end
            opOpImm: begin
                bSrc     = bSrcImm;
                aluLow   = {funct7[5] && (funct3 == 3'b101), funct3};
                // shamt is 6 bits on rv64, so funct7[0] belongs to it
                groupErr = isShift && (funct7[6:1] != 6'b000000)
                                   && (funct7[6:1] != 6'b010000);
            end
            opOpImmW: begin
                bSrc     = bSrcImm;
                aluLow   = {funct7[5] && (funct3 == 3'b101), funct3};
                groupErr = isShift && (funct7 != 7'b0000000)
                                   && (funct7 != 7'b0100000);
            end
            opOp, opOpW: begin
                aluLow   = {funct7[5], funct3};
                groupErr = (funct7 != 7'b0000000) && (funct7 != 7'b0100000)
                        && (funct7 != 7'b0000001);
            end
            default: begin
                groupErr = 1'b1; // unknown group
            end
        endcase
    end

    assign ctrl.extOp      = extOp;
    assign ctrl.bSrc       = bSrc;
    assign ctrl.branch     = branch;
    assign ctrl.aluCtrl[5] = ((group == opOp) || (group == opOpW)) && funct7[0]; // mul/div
    assign ctrl.aluCtrl[4] = (group == opOpImmW) || (group == opOpW);
    assign ctrl.aluCtrl[3:0] = aluLow;
    assign ctrl.aSrc     = (group == opAuipc) || (group == opJal) || (group == opJalr);
    assign ctrl.memRead  = (group == opLoad);
    assign ctrl.memToReg = (group == opLoad);
    assign ctrl.memWrite = (group == opStore);
    assign ctrl.regWrite = (group != opBranch) && (group != opStore) && (group != opSystem);
    assign ctrl.memOp    = funct3;
    assign ctrl.halt     = (group == opSystem);
    assign ctrl.illegal  = groupErr || (inst[1:0] != 2'b11);

endmodule

`default_nettype wire

// File: design/ctrlBus.sv
`timescale 1ns/1ns
`default_nettype none

interface ctrlBus;
    import decodePkg::*;

    extOpT   extOp;
    aluCtrlT aluCtrl;
    logic    aSrc;       // 1 selects pc
    bSrcT    bSrc;
    branchT  branch;
    logic    memRead;
    logic    memWrite;
    logic    memToReg;
    logic    regWrite;
    memOpT   memOp;
    logic    illegal;
    logic    halt;

    modport controller (
        output extOp, aluCtrl, aSrc, bSrc, branch, memRead, memWrite,
               memToReg, regWrite, memOp, illegal, halt
    );

    modport consumer (
        input extOp, aluCtrl, aSrc, bSrc, branch, memRead, memWrite,
              memToReg, regWrite, memOp, illegal, halt
    );

    modport immSource (input extOp);

endinterface

`default_nettype wire

// File: design/decodePkg.sv
`default_nettype none

package decodePkg;

    localparam int xlen         = 64;
    localparam int instWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int regCount     = 32;

    typedef logic [xlen-1:0]         xlenT;
    typedef logic [instWidth-1:0]    instT;
    typedef logic [xlen-1:0]         pcT;
    typedef logic [regAddrWidth-1:0] regAddrT;
    typedef logic [2:0]              extOpT;
    typedef logic [5:0]              aluCtrlT;   // m, word, sub/arith, func[2:0]
    typedef logic [2:0]              branchT;
    typedef logic [2:0]              memOpT;     // same as funct3
    typedef logic [1:0]              bSrcT;
    typedef logic [4:0]              opGroupT;   // inst[6:2]

    // immediate formats, generator decodes single bits of these
    localparam extOpT extI = 3'b000;
    localparam extOpT extJ = 3'b001;
    localparam extOpT extS = 3'b010;
    localparam extOpT extB = 3'b011;
    localparam extOpT extU = 3'b101;

    localparam bSrcT bSrcRs2  = 2'd0;
    localparam bSrcT bSrcFour = 2'd1;
    localparam bSrcT bSrcImm  = 2'd2;

    localparam branchT branchNone = 3'b000;
    localparam branchT branchJal  = 3'b001;
    localparam branchT branchJalr = 3'b010;
    localparam branchT branchEq   = 3'b100;
    localparam branchT branchNe   = 3'b101;
    localparam branchT branchLt   = 3'b110;
    localparam branchT branchGe   = 3'b111;

    localparam opGroupT opLoad   = 5'b00000;
    localparam opGroupT opStore  = 5'b01000;
    localparam opGroupT opOpImm  = 5'b00100;
    localparam opGroupT opOpImmW = 5'b00110;
    localparam opGroupT opOp     = 5'b01100;
    localparam opGroupT opOpW    = 5'b01110;
    localparam opGroupT opLui    = 5'b01101;
    localparam opGroupT opAuipc  = 5'b00101;
    localparam opGroupT opJal    = 5'b11011;
    localparam opGroupT opJalr   = 5'b11001;
    localparam opGroupT opBranch = 5'b11000;
    localparam opGroupT opSystem = 5'b11100;

endpackage

`default_nettype wire
